// File: front_issue.f
design/issue_pkg.sv
design/inst_fetcher.sv
design/issue_unit.sv
design/rs_entry.sv
design/dispatch_select.sv
design/front_issue_top.sv
testbench/tb_clock_gen.sv
testbench/tb_front_issue.sv

// File: run.sh
#!/usr/bin/env bash
# Build the front end testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_front_issue \
    -f front_issue.f -o sim_front_issue || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/sim_front_issue)" || true
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1

// File: testbench/tb_front_issue.sv
/* Testbench for the issue front end with a random RV32I program and
   memory, ALU and CDB models checked against an in-order reference */
module tb_front_issue;
    timeunit 1ns;
    timeprecision 100ps;
    import issue_pkg::*;

    localparam int PROG_LEN    = 160;
    localparam int DRAIN_LIMIT = 6000;
    localparam int T_RESET     = 0;
    localparam int T_FETCH     = 1;
    localparam int T_DISP      = 2;
    localparam int T_OPND      = 3;
    localparam int T_STABLE    = 4;
    localparam int T_DRAIN     = 5;

    logic             clk_in;
    logic             arst_n;
    logic             imem_req_valid;
    logic [XLEN-1:0]  imem_pc;
    logic             imem_req_ready;
    logic             imem_rsp_valid;
    logic [XLEN-1:0]  imem_rsp_inst;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0]  cdb_value;
    logic             exec_valid;
    logic             exec_ready;
    alu_op_e          exec_op;
    logic [TAG_W-1:0] exec_tag;
    logic [XLEN-1:0]  exec_pc;
    logic [XLEN-1:0]  exec_src1;
    logic [XLEN-1:0]  exec_src2;

    // Program image and what the in-order reference expects at each PC
    logic [XLEN-1:0]  prog       [PROG_LEN];
    logic             legal      [PROG_LEN];
    logic             dispatched [PROG_LEN];
    alu_op_e          exp_op     [PROG_LEN];
    logic [XLEN-1:0]  exp_src1   [PROG_LEN];
    logic [XLEN-1:0]  exp_src2   [PROG_LEN];

    logic [XLEN-1:0]  rsp_word_q [$];
    int               rsp_due_q  [$];
    logic [TAG_W-1:0] cdb_tag_q  [$];
    logic [XLEN-1:0]  cdb_val_q  [$];
    int               cdb_due_q  [$];

    integer           seed;
    int               cyc;
    int               rsp_last;
    int               cdb_last;
    int               stall_left;
    int               legal_cnt;
    int               dispatch_cnt;
    int               checks;
    int               errs [6];
    logic [XLEN-1:0]  req_pc;
    logic             offer_held;
    alu_op_e          held_op;
    logic [TAG_W-1:0] held_tag;
    logic [XLEN-1:0]  held_pc;
    logic [XLEN-1:0]  held_src1;
    logic [XLEN-1:0]  held_src2;

    tb_clock_gen u_tb_clock_gen (
        .clk_in (clk_in),
        .arst_n (arst_n)
    );

    front_issue_top u_front_issue_top (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .imem_req_valid (imem_req_valid),
        .imem_pc        (imem_pc),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_inst  (imem_rsp_inst),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .exec_valid     (exec_valid),
        .exec_ready     (exec_ready),
        .exec_op        (exec_op),
        .exec_tag       (exec_tag),
        .exec_pc        (exec_pc),
        .exec_src1      (exec_src1),
        .exec_src2      (exec_src2)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % 32'(n));
    endfunction

    // Standard RV32I encodings for the six kept operations
    function automatic logic [XLEN-1:0] encode(input alu_op_e op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'b000;
        f7 = 7'b0000000;
        case (op)
            OP_SUB:  f7 = 7'b0100000;
            OP_XOR:  f3 = 3'b100;
            OP_OR:   f3 = 3'b110;
            OP_AND:  f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        if (op == OP_ADDI) begin
            return {imm, rs1, 3'b000, rd, 7'b0010011};
        end else begin
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end
    endfunction

    function automatic logic [XLEN-1:0] alu_result(input alu_op_e op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        case (op)
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr[XLEN-1:2]);
        if (idx < PROG_LEN) begin
            return prog[idx];
        end else begin
            return '0;
        end
    endfunction

    function automatic logic drained();
        return dispatch_cnt == legal_cnt && cdb_due_q.size() == 0 && !cdb_valid;
    endfunction

    task automatic check_op(input string name, input alu_op_e got, input alu_op_e exp,
                            input int test_id);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            errs[test_id]++;
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp, input int test_id);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
            errs[test_id]++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp, input int test_id);
        checks++;
        if (got != exp) begin
            $display("MISMATCH %0t %s got %0d expected %0d", $time, name, got, exp);
            errs[test_id]++;
        end
    endtask

    task automatic note_failure(input string msg, input int test_id);
        $display("ERROR %0t %s", $time, msg);
        errs[test_id]++;
    endtask

    task automatic report_test(input string name, input int test_id);
        $display("test %s: %s (%0d errors)", name, errs[test_id] == 0 ? "pass" : "fail",
                 errs[test_id]);
    endtask

    task automatic build_program();
        logic [XLEN-1:0] ref_regs [NUM_REGS];
        alu_op_e         op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [11:0]     imm;
        int              imm_val;
        for (int r = 0; r < NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        legal_cnt = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            dispatched[i] = 1'b0;
            legal[i]      = 1'b0;
            if (rand_below(10) == 0) begin
                // Branch opcode, dropped at decode
                prog[i] = {25'($random(seed)), 7'b1100011};
            end else begin
                // Few registers so that hazards are common
                op          = alu_op_e'(3'(rand_below(6)));
                rd          = 5'(rand_below(8));
                rs1         = 5'(rand_below(8));
                rs2         = 5'(rand_below(8));
                imm_val     = rand_below(4096) - 2048;
                imm         = 12'(imm_val);
                prog[i]     = encode(op, rd, rs1, rs2, imm);
                legal[i]    = 1'b1;
                exp_op[i]   = op;
                exp_src1[i] = ref_regs[rs1];
                exp_src2[i] = (op == OP_ADDI) ? XLEN'(imm_val) : ref_regs[rs2];
                legal_cnt++;
                if (rd != 5'd0) begin
                    ref_regs[rd] = alu_result(op, exp_src1[i], exp_src2[i]);
                end
            end
        end
    endtask

    // Sampled mid-cycle, so these are the handshakes of the coming edge
    task automatic sample_cycle();
        int   idx;
        int   due;
        logic tag_busy;
        if (imem_req_valid && imem_req_ready) begin
            check_word("imem_pc", imem_pc, req_pc, T_FETCH);
            req_pc = req_pc + 32'd4;
            due    = cyc + 1 + rand_below(4);
            if (due <= rsp_last) begin
                due = rsp_last + 1;
            end
            rsp_last = due;
            rsp_word_q.push_back(fetch_word(imem_pc));
            rsp_due_q.push_back(due);
        end
        if (offer_held) begin
            if (!exec_valid) begin
                note_failure("exec_valid dropped before the offer was accepted", T_STABLE);
            end else begin
                check_op("exec_op (held)", exec_op, held_op, T_STABLE);
                check_word("exec_tag (held)", XLEN'(exec_tag), XLEN'(held_tag), T_STABLE);
                check_word("exec_pc (held)", exec_pc, held_pc, T_STABLE);
                check_word("exec_src1 (held)", exec_src1, held_src1, T_STABLE);
                check_word("exec_src2 (held)", exec_src2, held_src2, T_STABLE);
            end
        end
        if (exec_valid && exec_ready) begin
            idx = int'(exec_pc[XLEN-1:2]);
            if (idx >= PROG_LEN || !legal[idx]) begin
                note_failure($sformatf("illegal word at pc %h reached the exec port", exec_pc),
                             T_DISP);
            end else if (dispatched[idx]) begin
                note_failure($sformatf("word at pc %h dispatched twice", exec_pc), T_DISP);
            end else begin
                dispatched[idx] = 1'b1;
                check_op("exec_op", exec_op, exp_op[idx], T_DISP);
                check_word("exec_src1", exec_src1, exp_src1[idx], T_OPND);
                check_word("exec_src2", exec_src2, exp_src2[idx], T_OPND);
            end
            // A tag stays taken until its result has been broadcast
            tag_busy = cdb_valid && cdb_tag == exec_tag;
            foreach (cdb_tag_q[k]) begin
                if (cdb_tag_q[k] == exec_tag) begin
                    tag_busy = 1'b1;
                end
            end
            if (tag_busy) begin
                note_failure($sformatf("tag %0d dispatched before its result was broadcast",
                                       exec_tag), T_DISP);
            end
            dispatch_cnt++;
            due = cyc + 1 + rand_below(4);
            if (due <= cdb_last) begin
                due = cdb_last + 1;
            end
            cdb_last = due;
            cdb_tag_q.push_back(exec_tag);
            cdb_val_q.push_back(alu_result(exec_op, exec_src1, exec_src2));
            cdb_due_q.push_back(due);
        end
        offer_held = exec_valid && !exec_ready;
        held_op    = exec_op;
        held_tag   = exec_tag;
        held_pc    = exec_pc;
        held_src1  = exec_src1;
        held_src2  = exec_src2;
    endtask

    task automatic drive_cycle();
        cyc++;
        imem_req_ready = (rand_below(2) == 1);
        // Occasional stretches of exec back-pressure
        if (stall_left > 0) begin
            exec_ready = 1'b0;
            stall_left--;
        end else if (rand_below(6) == 0) begin
            exec_ready = 1'b0;
            stall_left = rand_below(6);
        end else begin
            exec_ready = 1'b1;
        end
        imem_rsp_valid = 1'b0;
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
            imem_rsp_valid = 1'b1;
            imem_rsp_inst  = rsp_word_q.pop_front();
            void'(rsp_due_q.pop_front());
        end
        cdb_valid = 1'b0;
        if (cdb_due_q.size() > 0 && cdb_due_q[0] <= cyc) begin
            cdb_valid = 1'b1;
            cdb_tag   = cdb_tag_q.pop_front();
            cdb_value = cdb_val_q.pop_front();
            void'(cdb_due_q.pop_front());
        end
    endtask

    initial begin : main
        int n;
        int total;
        int missing;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_inst  = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        exec_ready     = 1'b0;
        seed           = 57327;
        cyc            = 0;
        rsp_last       = 0;
        cdb_last       = 0;
        stall_left     = 0;
        dispatch_cnt   = 0;
        checks         = 0;
        req_pc         = '0;
        offer_held     = 1'b0;
        for (int t = 0; t < 6; t++) begin
            errs[t] = 0;
        end
        build_program();

        n = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(negedge clk_in);
            check_word("imem_req_valid", XLEN'(imem_req_valid), '0, T_RESET);
            check_word("exec_valid", XLEN'(exec_valid), '0, T_RESET);
            n++;
        end
        if (arst_n !== 1'b1) begin
            note_failure("reset was never released", T_RESET);
        end
        report_test("reset", T_RESET);

        n = 0;
        while (!drained() && n < DRAIN_LIMIT) begin
            @(negedge clk_in);
            sample_cycle();
            @(posedge clk_in);
            #1;
            drive_cycle();
            n++;
        end
        if (!drained()) begin
            note_failure($sformatf("program did not drain within %0d cycles", DRAIN_LIMIT),
                         T_DRAIN);
        end
        @(negedge clk_in);
        missing = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (legal[i] && !dispatched[i]) begin
                missing++;
            end
        end
        check_count("dispatches", dispatch_cnt, legal_cnt, T_DRAIN);
        check_count("undispatched legal words", missing, 0, T_DRAIN);
        check_word("exec_valid", XLEN'(exec_valid), '0, T_DRAIN);

        report_test("fetch", T_FETCH);
        report_test("dispatch", T_DISP);
        report_test("operands", T_OPND);
        report_test("stability", T_STABLE);
        report_test("drain", T_DRAIN);
        total = 0;
        for (int t = 0; t < 6; t++) begin
            total += errs[t];
        end
        $display("checks %0d, dispatches %0d of %0d legal, errors %0d",
                 checks, dispatch_cnt, legal_cnt, total);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
/* Testbench clock and reset, 10 ns clock with reset held low for 3 cycles */
module tb_clock_gen (
    output logic clk_in,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_in = 1'b0;
        forever begin
            #5 clk_in = ~clk_in;
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk_in);
        #1 arst_n = 1'b1;
    end

endmodule

// File: design/front_issue_top.sv
/* Front end top, fetcher and issue unit feeding reservation stations
   and a single execution port */
module front_issue_top (
    input  logic                        clk_in,
    input  logic                        arst_n,
    output logic                        imem_req_valid,
    output logic [issue_pkg::XLEN-1:0]  imem_pc,
    input  logic                        imem_req_ready,
    input  logic                        imem_rsp_valid,
    input  logic [issue_pkg::XLEN-1:0]  imem_rsp_inst,
    input  logic                        cdb_valid,
    input  logic [issue_pkg::TAG_W-1:0] cdb_tag,
    input  logic [issue_pkg::XLEN-1:0]  cdb_value,
    output logic                        exec_valid,
    input  logic                        exec_ready,
    output issue_pkg::alu_op_e          exec_op,
    output logic [issue_pkg::TAG_W-1:0] exec_tag,
    output logic [issue_pkg::XLEN-1:0]  exec_pc,
    output logic [issue_pkg::XLEN-1:0]  exec_src1,
    output logic [issue_pkg::XLEN-1:0]  exec_src2
);
    import issue_pkg::*;

    logic              q_valid;
    logic [XLEN-1:0]   q_inst;
    logic [XLEN-1:0]   q_pc;
    logic              q_ready;
    rs_state_e         entry_state [NUM_RS];
    alu_op_e           entry_op    [NUM_RS];
    logic [XLEN-1:0]   entry_pc    [NUM_RS];
    logic [XLEN-1:0]   entry_src1  [NUM_RS];
    logic [XLEN-1:0]   entry_src2  [NUM_RS];
    logic [NUM_RS-1:0] alloc;
    logic [NUM_RS-1:0] grant;
    alu_op_e           alloc_op;
    logic [XLEN-1:0]   alloc_pc;
    logic [XLEN-1:0]   alloc_val1;
    logic [XLEN-1:0]   alloc_val2;
    logic              alloc_has_dep1;
    logic [TAG_W-1:0]  alloc_dep1;
    logic              alloc_has_dep2;
    logic [TAG_W-1:0]  alloc_dep2;

    inst_fetcher u_inst_fetcher (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .imem_req_valid (imem_req_valid),
        .imem_pc        (imem_pc),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_inst  (imem_rsp_inst),
        .q_valid        (q_valid),
        .q_inst         (q_inst),
        .q_pc           (q_pc),
        .q_ready        (q_ready)
    );

    issue_unit u_issue_unit (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .q_valid        (q_valid),
        .q_inst         (q_inst),
        .q_pc           (q_pc),
        .q_ready        (q_ready),
        .entry_state    (entry_state),
        .alloc          (alloc),
        .alloc_op       (alloc_op),
        .alloc_pc       (alloc_pc),
        .alloc_val1     (alloc_val1),
        .alloc_val2     (alloc_val2),
        .alloc_has_dep1 (alloc_has_dep1),
        .alloc_dep1     (alloc_dep1),
        .alloc_has_dep2 (alloc_has_dep2),
        .alloc_dep2     (alloc_dep2),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
        rs_entry #(
            .ENTRY_ID (i)
        ) u_rs_entry (
            .clk_in         (clk_in),
            .arst_n         (arst_n),
            .alloc          (alloc[i]),
            .alloc_op       (alloc_op),
            .alloc_pc       (alloc_pc),
            .alloc_val1     (alloc_val1),
            .alloc_val2     (alloc_val2),
            .alloc_has_dep1 (alloc_has_dep1),
            .alloc_dep1     (alloc_dep1),
            .alloc_has_dep2 (alloc_has_dep2),
            .alloc_dep2     (alloc_dep2),
            .cdb_valid      (cdb_valid),
            .cdb_tag        (cdb_tag),
            .cdb_value      (cdb_value),
            .grant          (grant[i]),
            .state          (entry_state[i]),
            .op             (entry_op[i]),
            .pc             (entry_pc[i]),
            .src1           (entry_src1[i]),
            .src2           (entry_src2[i])
        );
    end

    dispatch_select u_dispatch_select (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .entry_state (entry_state),
        .entry_op    (entry_op),
        .entry_pc    (entry_pc),
        .entry_src1  (entry_src1),
        .entry_src2  (entry_src2),
        .grant       (grant),
        .exec_valid  (exec_valid),
        .exec_op     (exec_op),
        .exec_tag    (exec_tag),
        .exec_pc     (exec_pc),
        .exec_src1   (exec_src1),
        .exec_src2   (exec_src2),
        .exec_ready  (exec_ready)
    );

endmodule

// File: design/dispatch_select.sv
/* Dispatch select that offers the lowest ready entry on the execution port */
module dispatch_select (
    input  logic                         clk_in,
    input  logic                         arst_n,
    input  issue_pkg::rs_state_e         entry_state [issue_pkg::NUM_RS],
    input  issue_pkg::alu_op_e           entry_op    [issue_pkg::NUM_RS],
    input  logic [issue_pkg::XLEN-1:0]   entry_pc    [issue_pkg::NUM_RS],
    input  logic [issue_pkg::XLEN-1:0]   entry_src1  [issue_pkg::NUM_RS],
    input  logic [issue_pkg::XLEN-1:0]   entry_src2  [issue_pkg::NUM_RS],
    output logic [issue_pkg::NUM_RS-1:0] grant,
    output logic                         exec_valid,
    output issue_pkg::alu_op_e           exec_op,
    output logic [issue_pkg::TAG_W-1:0]  exec_tag,
    output logic [issue_pkg::XLEN-1:0]   exec_pc,
    output logic [issue_pkg::XLEN-1:0]   exec_src1,
    output logic [issue_pkg::XLEN-1:0]   exec_src2,
    input  logic                         exec_ready
);
    import issue_pkg::*;

    logic             any_ready;
    logic [TAG_W-1:0] first_ready;
    logic             held;
    logic [TAG_W-1:0] held_tag;

    always_comb begin
        any_ready   = 1'b0;
        first_ready = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (entry_state[i] == RS_READY) begin
                any_ready   = 1'b1;
                first_ready = TAG_W'(i);
            end
        end
    end

    // A stalled offer keeps its entry until accepted
    assign exec_valid = any_ready;
    assign exec_tag   = held ? held_tag : first_ready;
    assign exec_op    = entry_op[exec_tag];
    assign exec_pc    = entry_pc[exec_tag];
    assign exec_src1  = entry_src1[exec_tag];
    assign exec_src2  = entry_src2[exec_tag];

    always_comb begin
        grant = '0;
        if (exec_valid && exec_ready) begin
            grant[exec_tag] = 1'b1;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            held     <= 1'b0;
            held_tag <= '0;
        end else begin
            held     <= exec_valid && !exec_ready;
            held_tag <= exec_tag;
        end
    end

endmodule

// File: design/rs_entry.sv
/* Reservation station entry, waits on CDB tags and requests dispatch */
module rs_entry #(
    parameter int ENTRY_ID = 0
) (
    input  logic                        clk_in,
    input  logic                        arst_n,
    input  logic                        alloc,
    input  issue_pkg::alu_op_e          alloc_op,
    input  logic [issue_pkg::XLEN-1:0]  alloc_pc,
    input  logic [issue_pkg::XLEN-1:0]  alloc_val1,
    input  logic [issue_pkg::XLEN-1:0]  alloc_val2,
    input  logic                        alloc_has_dep1,
    input  logic [issue_pkg::TAG_W-1:0] alloc_dep1,
    input  logic                        alloc_has_dep2,
    input  logic [issue_pkg::TAG_W-1:0] alloc_dep2,
    input  logic                        cdb_valid,
    input  logic [issue_pkg::TAG_W-1:0] cdb_tag,
    input  logic [issue_pkg::XLEN-1:0]  cdb_value,
    input  logic                        grant,
    output issue_pkg::rs_state_e        state,
    output issue_pkg::alu_op_e          op,
    output logic [issue_pkg::XLEN-1:0]  pc,
    output logic [issue_pkg::XLEN-1:0]  src1,
    output logic [issue_pkg::XLEN-1:0]  src2
);
    import issue_pkg::*;

    logic             has_dep1;
    logic [TAG_W-1:0] dep1;
    logic             has_dep2;
    logic [TAG_W-1:0] dep2;
    logic             hit1;
    logic             hit2;
    logic             own_done;

    assign hit1     = cdb_valid && has_dep1 && cdb_tag == dep1;
    assign hit2     = cdb_valid && has_dep2 && cdb_tag == dep2;
    assign own_done = cdb_valid && cdb_tag == TAG_W'(ENTRY_ID);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RS_EMPTY;
            has_dep1 <= 1'b0;
            has_dep2 <= 1'b0;
        end else begin
            case (state)
                RS_EMPTY: begin
                    if (alloc) begin
                        has_dep1 <= alloc_has_dep1;
                        has_dep2 <= alloc_has_dep2;
                        state    <= (alloc_has_dep1 || alloc_has_dep2) ? RS_WAIT : RS_READY;
                    end
                end
                RS_WAIT: begin
                    if (hit1) begin
                        has_dep1 <= 1'b0;
                    end
                    if (hit2) begin
                        has_dep2 <= 1'b0;
                    end
                    if ((!has_dep1 || hit1) && (!has_dep2 || hit2)) begin
                        state <= RS_READY;
                    end
                end
                RS_READY: begin
                    if (grant) begin
                        state <= RS_EXEC;
                    end
                end
                RS_EXEC: begin
                    // Tag is free once our own result is broadcast
                    if (own_done) begin
                        state <= RS_EMPTY;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == RS_EMPTY && alloc) begin
            op   <= alloc_op;
            pc   <= alloc_pc;
            src1 <= alloc_val1;
            src2 <= alloc_val2;
            dep1 <= alloc_dep1;
            dep2 <= alloc_dep2;
        end else if (state == RS_WAIT) begin
            if (hit1) begin
                src1 <= cdb_value;
            end
            if (hit2) begin
                src2 <= cdb_value;
            end
        end
    end

endmodule

// File: design/issue_unit.sv
/* Issue unit, decodes queued words, tracks register status
   and allocates reservation station entries */
module issue_unit (
    input  logic                         clk_in,
    input  logic                         arst_n,
    input  logic                         q_valid,
    input  logic [issue_pkg::XLEN-1:0]   q_inst,
    input  logic [issue_pkg::XLEN-1:0]   q_pc,
    output logic                         q_ready,
    input  issue_pkg::rs_state_e         entry_state [issue_pkg::NUM_RS],
    output logic [issue_pkg::NUM_RS-1:0] alloc,
    output issue_pkg::alu_op_e           alloc_op,
    output logic [issue_pkg::XLEN-1:0]   alloc_pc,
    output logic [issue_pkg::XLEN-1:0]   alloc_val1,
    output logic [issue_pkg::XLEN-1:0]   alloc_val2,
    output logic                         alloc_has_dep1,
    output logic [issue_pkg::TAG_W-1:0]  alloc_dep1,
    output logic                         alloc_has_dep2,
    output logic [issue_pkg::TAG_W-1:0]  alloc_dep2,
    input  logic                         cdb_valid,
    input  logic [issue_pkg::TAG_W-1:0]  cdb_tag,
    input  logic [issue_pkg::XLEN-1:0]   cdb_value
);
    import issue_pkg::*;

    logic [XLEN-1:0]  regs     [NUM_REGS];
    logic             reg_busy [NUM_REGS];
    logic [TAG_W-1:0] reg_tag  [NUM_REGS];

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic             legal;
    alu_op_e          dec_op;
    logic             has_free;
    logic [TAG_W-1:0] free_tag;
    logic             issue;

    assign opcode = q_inst[6:0];
    assign rd     = q_inst[11:7];
    assign funct3 = q_inst[14:12];
    assign rs1    = q_inst[19:15];
    assign rs2    = q_inst[24:20];
    assign funct7 = q_inst[31:25];

    always_comb begin
        legal  = 1'b0;
        dec_op = OP_ADD;
        if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin
            legal  = 1'b1;
            dec_op = OP_ADDI;
        end else if (opcode == OPC_OP && funct7 == 7'b0100000 && funct3 == 3'b000) begin
            legal  = 1'b1;
            dec_op = OP_SUB;
        end else if (opcode == OPC_OP && funct7 == 7'b0000000) begin
            legal = 1'b1;
            case (funct3)
                3'b000:  dec_op = OP_ADD;
                3'b100:  dec_op = OP_XOR;
                3'b110:  dec_op = OP_OR;
                3'b111:  dec_op = OP_AND;
                default: legal  = 1'b0;
            endcase
        end
    end

    // Lowest empty entry wins
    always_comb begin
        has_free = 1'b0;
        free_tag = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (entry_state[i] == RS_EMPTY) begin
                has_free = 1'b1;
                free_tag = TAG_W'(i);
            end
        end
    end

    // Illegal words are popped and dropped
    assign q_ready = has_free || !legal;
    assign issue   = q_valid && legal && has_free;

    always_comb begin
        alloc = '0;
        if (issue) begin
            alloc[free_tag] = 1'b1;
        end
    end

    function automatic void read_src(
        input  logic [REG_W-1:0] r,
        output logic [XLEN-1:0]  val,
        output logic             has_dep,
        output logic [TAG_W-1:0] dep
    );
        val     = regs[r];
        has_dep = 1'b0;
        dep     = reg_tag[r];
        if (r == '0) begin
            val = '0;
        end else if (reg_busy[r]) begin
            // Result on the CDB right now is taken directly
            if (cdb_valid && cdb_tag == reg_tag[r]) begin
                val = cdb_value;
            end else begin
                has_dep = 1'b1;
            end
        end
    endfunction

    always_comb begin
        read_src(rs1, alloc_val1, alloc_has_dep1, alloc_dep1);
        read_src(rs2, alloc_val2, alloc_has_dep2, alloc_dep2);
        if (dec_op == OP_ADDI) begin
            alloc_val2     = {{(XLEN - 12){q_inst[31]}}, q_inst[31:20]};
            alloc_has_dep2 = 1'b0;
        end
    end

    assign alloc_op = dec_op;
    assign alloc_pc = q_pc;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r]     <= '0;
                reg_busy[r] <= 1'b0;
                reg_tag[r]  <= '0;
            end
        end else begin
            for (int r = 1; r < NUM_REGS; r++) begin
                if (cdb_valid && reg_busy[r] && reg_tag[r] == cdb_tag) begin
                    regs[r]     <= cdb_value;
                    reg_busy[r] <= 1'b0;
                end
            end
            // Newest writer of rd owns its status
            if (issue && rd != '0) begin
                reg_busy[rd] <= 1'b1;
                reg_tag[rd]  <= free_tag;
            end
        end
    end

endmodule

// File: design/inst_fetcher.sv
/* Instruction fetcher, sequential PC with imem request handshake
   and a two-word instruction queue */
module inst_fetcher (
    input  logic                       clk_in,
    input  logic                       arst_n,
    output logic                       imem_req_valid,
    output logic [issue_pkg::XLEN-1:0] imem_pc,
    input  logic                       imem_req_ready,
    input  logic                       imem_rsp_valid,
    input  logic [issue_pkg::XLEN-1:0] imem_rsp_inst,
    output logic                       q_valid,
    output logic [issue_pkg::XLEN-1:0] q_inst,
    output logic [issue_pkg::XLEN-1:0] q_pc,
    input  logic                       q_ready
);
    import issue_pkg::*;

    logic [XLEN-1:0] fifo_inst [QUEUE_DEPTH];
    logic [XLEN-1:0] fifo_pc   [QUEUE_DEPTH];
    logic            wr_ptr;
    logic            rd_ptr;
    logic [1:0]      count;
    logic [1:0]      outstanding;
    logic [XLEN-1:0] rsp_pc;
    logic            running;
    logic            req_fire;
    logic            pop;

    // Every outstanding response must already own a queue slot
    assign imem_req_valid = running && (int'(count) + int'(outstanding) < QUEUE_DEPTH);
    assign req_fire       = imem_req_valid && imem_req_ready;

    assign q_valid = (count != 2'd0);
    assign q_inst  = fifo_inst[rd_ptr];
    assign q_pc    = fifo_pc[rd_ptr];
    assign pop     = q_valid && q_ready;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            running     <= 1'b0;
            imem_pc     <= '0;
            rsp_pc      <= '0;
            outstanding <= '0;
            count       <= '0;
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
        end else begin
            running     <= 1'b1;
            outstanding <= outstanding + 2'(req_fire) - 2'(imem_rsp_valid);
            count       <= count + 2'(imem_rsp_valid) - 2'(pop);
            if (req_fire) begin
                imem_pc <= imem_pc + 32'd4;
            end
            // Responses return in order, so their PC just counts up
            if (imem_rsp_valid) begin
                rsp_pc <= rsp_pc + 32'd4;
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (imem_rsp_valid) begin
            fifo_inst[wr_ptr] <= imem_rsp_inst;
            fifo_pc[wr_ptr]   <= rsp_pc;
        end
    end

endmodule

// File: design/issue_pkg.sv
/* Shared widths, sizes and encodings for the RV32I issue front end */
package issue_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_RS      = 4;
    localparam int TAG_W       = 2;
    localparam int REG_W       = 5;
    localparam int NUM_REGS    = 1 << REG_W;
    localparam int QUEUE_DEPTH = 2;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        RS_EMPTY = 2'd0,
        RS_WAIT  = 2'd1,
        RS_READY = 2'd2,
        RS_EXEC  = 2'd3
    } rs_state_e;

endpackage
